/* rtl/panel_pkg.sv */
// display panel shared types
`default_nettype none

package panel_pkg;

	// one serial frame, eight digits of eight bits
	localparam int FRAME_BITS = 64;

	// status word from the core, inst in the top bits
	typedef struct packed {
		logic [31:0] inst;
		logic [3:0]  pc_nib;
		logic        flush;
	} status_word_t;

	// one digit, active low
	// 0 means the segment is lit
	typedef struct packed {
		logic dp;
		logic g;
		logic f;
		logic e;
		logic d;
		logic c;
		logic b;
		logic a;
	} seg_byte_t;

	// digit 7 sits in the top byte, shifted out first
	typedef seg_byte_t [7:0] seg_frame_t;

	// control fsm states, visited in this order
	typedef enum logic [2:0] {
		IDLE,
		ENCODE,
		CLEAR,
		SHIFT,
		DONE
	} panel_state_t;

endpackage

`default_nettype wire

/* rtl/tick_gen.sv */
// serial link tick generator
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
	// clk200m cycles per tick, at least 2
	parameter int DIV = 4
) (
	input  wire  clk200m,
	input  wire  rst_n,
	output logic tick
);

	// wide enough for 0 .. DIV-1
	localparam int CNT_W = (DIV > 2) ? $clog2(DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	// last count of the period
	assign wrap = (cnt == CNT_W'(DIV - 1));

	// free running, never stopped by the fsm
	always_ff @(posedge clk200m or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else begin
			if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			// registered, one cycle out of DIV
			tick <= wrap;
		end
	end

	// back to back ticks would break the clear and the shift pacing
	a_tick_spacing: assert property (@(posedge clk200m) disable iff (!rst_n)
		tick |=> !tick);

endmodule

`default_nettype wire

/* rtl/hex_seg_encoder.sv */
// hex to seven segment frame encoder
`timescale 1ns/1ns
`default_nettype none

module hex_seg_encoder (
	input  wire                   clk200m,
	input  wire                   rst_n,
	input  wire                   load,
	input  wire  [31:0]           word,
	output panel_pkg::seg_frame_t frame
);

	panel_pkg::seg_frame_t frame_nxt;

	// hex glyph, active high {g,f,e,d,c,b,a}
	function automatic logic [6:0] glyph(input logic [3:0] nib);
		logic [6:0] seg;
		case (nib)
			4'h0: seg = 7'h3f;
			4'h1: seg = 7'h06;
			4'h2: seg = 7'h5b;
			4'h3: seg = 7'h4f;
			4'h4: seg = 7'h66;
			4'h5: seg = 7'h6d;
			4'h6: seg = 7'h7d;
			4'h7: seg = 7'h07;
			4'h8: seg = 7'h7f;
			4'h9: seg = 7'h6f;
			// lower case b and d keep them apart from 8 and 0
			4'ha: seg = 7'h77;
			4'hb: seg = 7'h7c;
			4'hc: seg = 7'h39;
			4'hd: seg = 7'h5e;
			4'he: seg = 7'h79;
			default: seg = 7'h71;
		endcase
		return seg;
	endfunction

	// nibble i lands in byte i, digit 7 on top
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			// dp stays dark, segments inverted
			frame_nxt[i] = {1'b1, ~glyph(word[4*i +: 4])};
		end
	end

	// held while the serializer walks through it
	always_ff @(posedge clk200m or negedge rst_n) begin
		if (!rst_n) begin
			// blank display
			frame <= '1;
		end else if (load) begin
			frame <= frame_nxt;
		end
	end

endmodule

`default_nettype wire

/* rtl/seg_serializer.sv */
// segment frame serializer
`timescale 1ns/1ns
`default_nettype none

module seg_serializer (
	input  wire                   clk200m,
	input  wire                   rst_n,
	input  wire                   tick,
	input  wire                   start,
	input  wire                   clr_req,
	input  panel_pkg::seg_frame_t frame,
	output logic                  done,
	output logic                  s_clk,
	output logic                  s_clrn,
	output logic                  sout,
	output logic                  en
);

	localparam int CNT_W = $clog2(panel_pkg::FRAME_BITS);

	logic [panel_pkg::FRAME_BITS-1:0] sr;
	logic [CNT_W-1:0]                 bit_cnt;
	logic                             shifting;
	logic                             clearing;
	logic                             last_bit;

	assign last_bit = (bit_cnt == CNT_W'(panel_pkg::FRAME_BITS - 1));

	// frame payload, msb leaves first
	always_ff @(posedge clk200m) begin
		if (start) begin
			sr <= frame;
		end else if (shifting && tick && s_clk) begin
			sr <= {sr[panel_pkg::FRAME_BITS-2:0], 1'b0};
		end
	end

	always_ff @(posedge clk200m or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt  <= '0;
			shifting <= 1'b0;
			clearing <= 1'b0;
			done     <= 1'b0;
			s_clk    <= 1'b1;
			s_clrn   <= 1'b1;
			sout     <= 1'b0;
			en       <= 1'b0;
		end else begin
			done <= 1'b0;
			// en drops one cycle after the last rising edge
			if (done) begin
				en <= 1'b0;
			end
			if (start) begin
				bit_cnt  <= '0;
				shifting <= 1'b1;
			end else if (shifting && tick) begin
				if (s_clk) begin
					// falling edge, next bit out
					s_clk <= 1'b0;
					sout  <= sr[panel_pkg::FRAME_BITS-1];
					en    <= 1'b1;
				end else begin
					// rising edge, display samples here
					s_clk <= 1'b1;
					if (last_bit) begin
						shifting <= 1'b0;
						done     <= 1'b1;
					end else begin
						bit_cnt <= bit_cnt + 1'b1;
					end
				end
			end else if (clearing && tick) begin
				// one tick interval of clear is enough
				s_clrn   <= 1'b1;
				clearing <= 1'b0;
				done     <= 1'b1;
			end else if (clr_req && !shifting && !done && tick) begin
				s_clrn   <= 1'b0;
				clearing <= 1'b1;
			end
		end
	end

	// data only moves on the falling edge of s_clk
	a_sout_stable: assert property (@(posedge clk200m) disable iff (!rst_n)
		!$stable(sout) |-> !s_clk);

	// done only closes a clear or a frame in progress
	a_done_busy: assert property (@(posedge clk200m) disable iff (!rst_n)
		done |-> ($past(en) || $past(clearing)));

endmodule

`default_nettype wire

/* rtl/panel_ctrl.sv */
// display panel control fsm
`timescale 1ns/1ns
`default_nettype none

module panel_ctrl (
	input  wire                     clk200m,
	input  wire                     rst_n,
	input  wire                     status_valid,
	input  panel_pkg::status_word_t status,
	output logic                    status_ready,
	output logic                    enc_load,
	output logic [31:0]             enc_word,
	output logic                    clr_req,
	output logic                    ser_start,
	input  wire                     ser_done,
	output logic [7:0]              leds
);

	panel_pkg::panel_state_t state;
	panel_pkg::panel_state_t state_nxt;

	logic        armed;
	logic        take;
	logic [3:0]  led_pc;
	logic        led_flush;
	logic [31:0] word_q;

	// ready held off for one cycle out of reset
	assign status_ready = armed && (state == panel_pkg::IDLE);
	assign take         = status_valid && status_ready;

	// strobes straight from the state
	assign enc_load = (state == panel_pkg::ENCODE);
	assign clr_req  = (state == panel_pkg::CLEAR);
	assign enc_word = word_q;

	// bit 4 is busy and the top two stay 0
	assign leds = {2'b00, led_flush, (state != panel_pkg::IDLE), led_pc};

	always_comb begin
		state_nxt = state;
		case (state)
			panel_pkg::IDLE: begin
				if (take) begin
					state_nxt = panel_pkg::ENCODE;
				end
			end
			panel_pkg::ENCODE: state_nxt = panel_pkg::CLEAR;
			// first done closes the clear pulse
			panel_pkg::CLEAR: begin
				if (ser_done) begin
					state_nxt = panel_pkg::SHIFT;
				end
			end
			// second done closes the frame
			panel_pkg::SHIFT: begin
				if (ser_done) begin
					state_nxt = panel_pkg::DONE;
				end
			end
			panel_pkg::DONE: state_nxt = panel_pkg::IDLE;
			default: state_nxt = panel_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk200m or negedge rst_n) begin
		if (!rst_n) begin
			state     <= panel_pkg::IDLE;
			armed     <= 1'b0;
			ser_start <= 1'b0;
			led_pc    <= 4'h0;
			led_flush <= 1'b0;
		end else begin
			state <= state_nxt;
			armed <= 1'b1;
			// one cycle pulse on entry to SHIFT
			ser_start <= (state == panel_pkg::CLEAR) && ser_done;
			if (take) begin
				led_pc    <= status.pc_nib;
				led_flush <= status.flush;
			end
		end
	end

	// inst kept for the encoder
	always_ff @(posedge clk200m) begin
		if (take) begin
			word_q <= status.inst;
		end
	end

	// ready only while the serializer has nothing to report
	a_ready_idle: assert property (@(posedge clk200m) disable iff (!rst_n)
		status_ready |-> !ser_done);

	// a stretched clear done would close the frame before its first bit
	a_start_no_done: assert property (@(posedge clk200m) disable iff (!rst_n)
		ser_start |-> !ser_done);

endmodule

`default_nettype wire

/* rtl/panel_top.sv */
// display panel top level
`timescale 1ns/1ns
`default_nettype none

module panel_top #(
	// clk200m cycles per half period of s_clk
	parameter int DIV = 4
) (
	input  wire                     clk200m,
	input  wire                     rst_n,
	input  wire                     status_valid,
	input  panel_pkg::status_word_t status,
	output logic                    status_ready,
	output logic [7:0]              leds,
	output logic                    s_clk,
	output logic                    s_clrn,
	output logic                    sout,
	output logic                    en
);

	// ctrl to encoder
	logic                  enc_load;
	logic [31:0]           enc_word;
	panel_pkg::seg_frame_t frame;

	// ctrl to serializer and back
	logic                  clr_req;
	logic                  ser_start;
	logic                  ser_done;

	// link pacing
	logic                  tick;

	panel_ctrl u_ctrl (
		.clk200m      (clk200m),
		.rst_n        (rst_n),
		.status_valid (status_valid),
		.status       (status),
		.status_ready (status_ready),
		.enc_load     (enc_load),
		.enc_word     (enc_word),
		.clr_req      (clr_req),
		.ser_start    (ser_start),
		.ser_done     (ser_done),
		.leds         (leds)
	);

	hex_seg_encoder u_enc (
		.clk200m (clk200m),
		.rst_n   (rst_n),
		.load    (enc_load),
		.word    (enc_word),
		.frame   (frame)
	);

	tick_gen #(.DIV(DIV)) u_tick (
		.clk200m (clk200m),
		.rst_n   (rst_n),
		.tick    (tick)
	);

	seg_serializer u_ser (
		.clk200m (clk200m),
		.rst_n   (rst_n),
		.tick    (tick),
		.start   (ser_start),
		.clr_req (clr_req),
		.frame   (frame),
		.done    (ser_done),
		.s_clk   (s_clk),
		.s_clrn  (s_clrn),
		.sout    (sout),
		.en      (en)
	);

endmodule

`default_nettype wire

/* sim/clk_gen.sv */
// testbench clock and reset
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
	parameter int HALF_PERIOD  = 50,
	parameter int RESET_CYCLES = 16
) (
	output logic clk200m,
	output logic rst_n
);

	// 100 ns period
	initial begin
		clk200m = 1'b0;
		forever #(HALF_PERIOD) clk200m = ~clk200m;
	end

	// release mid high phase, away from both edges
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk200m);
		#25 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/panel_tb.sv */
// display panel testbench
`timescale 1ns/1ns
`default_nettype none

module panel_tb;

	localparam int NUM_FRAMES     = 40;
	localparam int FRAME_TIMEOUT  = 2000;
	localparam int ACCEPT_TIMEOUT = 5000;

	// active high hex glyphs as {g,f,e,d,c,b,a}
	localparam logic [6:0] GLYPHS [16] = '{
		7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
		7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
	};

	logic                    clk200m;
	logic                    rst_n;
	logic                    status_valid;
	panel_pkg::status_word_t status;
	logic                    status_ready;
	logic [7:0]              leds;
	logic                    s_clk;
	logic                    s_clrn;
	logic                    sout;
	logic                    en;

	// model state
	logic [31:0] q[$];
	logic [31:0] rng_state = 32'h04c08b4b;
	logic [63:0] shift_in;
	logic [63:0] exp_frame;
	logic        prev_s_clk;
	logic        prev_clrn;
	logic        ready_seen;
	int          bit_cnt;
	int          clr_count;
	int          frames_done;
	int          frame_cycles;

	clk_gen u_clk (
		.clk200m (clk200m),
		.rst_n   (rst_n)
	);

	panel_top #(.DIV(3)) DUT (
		.clk200m      (clk200m),
		.rst_n        (rst_n),
		.status_valid (status_valid),
		.status       (status),
		.status_ready (status_ready),
		.leds         (leds),
		.s_clk        (s_clk),
		.s_clrn       (s_clrn),
		.sout         (sout),
		.en           (en)
	);

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
		stop_run();
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR: %s", msg);
		stop_run();
	endtask

	// lcg with the numerical recipes constants
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// digit 7 in the top byte and dp dark
	function automatic logic [63:0] expected_frame(input logic [31:0] inst);
		logic [63:0] f;
		for (int d = 0; d < 8; d++) begin
			f[8*d +: 8] = {1'b1, ~GLYPHS[inst[4*d +: 4]]};
		end
		return f;
	endfunction

	// offer one word from a falling edge
	task automatic send_word(input panel_pkg::status_word_t w);
		int waited;
		logic [7:0] exp_leds;
		waited = 0;
		status       = w;
		status_valid = 1'b1;
		// valid stays up through back-pressure
		while (!status_ready) begin
			@(negedge clk200m);
			waited++;
			if (waited > ACCEPT_TIMEOUT) begin
				report_problem("timeout waiting for status_ready");
			end
		end
		// transfer on the coming rising edge
		assert (q.size() == 0) else begin
			report_problem("word accepted before the previous frame left the link");
		end
		q.push_back(w.inst);
		@(negedge clk200m);
		status_valid = 1'b0;
		status       = '0;
		// leds latch the new word and show busy
		exp_leds = {2'b00, w.flush, 1'b1, w.pc_nib};
		assert (leds === exp_leds) else begin
			report_mismatch("leds", 64'(exp_leds), 64'(leds));
		end
	endtask

	// serial link capture and continuous checks
	always @(negedge clk200m) begin
		if (rst_n) begin
			// idle level of s_clk
			if (!en) begin
				assert (s_clk === 1'b1) else begin
					report_mismatch("s_clk", 64'h1, 64'(s_clk));
				end
			end
			if (s_clk !== prev_s_clk) begin
				assert (en === 1'b1) else begin
					report_problem("s_clk toggled while en was low");
				end
			end
			if (prev_clrn && !s_clrn) begin
				clr_count++;
			end
			// busy flag mirrors ready once armed
			if (ready_seen) begin
				assert (leds[4] === !status_ready) else begin
					report_mismatch("leds[4]", 64'(!status_ready), 64'(leds[4]));
				end
			end
			if (status_ready) begin
				ready_seen = 1'b1;
			end
			// display samples on the rising edge
			if (!prev_s_clk && s_clk && en) begin
				if (bit_cnt == 0) begin
					assert (clr_count == 1) else begin
						report_mismatch("s_clrn pulses", 64'h1, 64'(clr_count));
					end
				end
				// clear pulse must be over before any bit lands
				assert (s_clrn === 1'b1) else begin
					report_mismatch("s_clrn", 64'h1, 64'(s_clrn));
				end
				shift_in = {shift_in[62:0], sout};
				bit_cnt++;
				if (bit_cnt == 64) begin
					assert (q.size() > 0) else begin
						report_problem("frame shifted out with no word accepted");
					end
					exp_frame = expected_frame(q.pop_front());
					assert (shift_in === exp_frame) else begin
						report_mismatch("sout frame", exp_frame, shift_in);
					end
					// no second clear inside the frame
					assert (clr_count == 1) else begin
						report_mismatch("s_clrn pulses", 64'h1, 64'(clr_count));
					end
					clr_count = 0;
					bit_cnt   = 0;
					frames_done++;
				end
			end
			// per frame watchdog
			if (q.size() > 0) begin
				frame_cycles++;
				if (frame_cycles > FRAME_TIMEOUT) begin
					report_problem("timeout waiting for a frame on the serial link");
				end
			end else begin
				frame_cycles = 0;
			end
			prev_s_clk = s_clk;
			prev_clrn  = s_clrn;
		end
	end

	initial begin
		panel_pkg::status_word_t w;
		logic [31:0] r;
		int gap;
		int waited;
		status_valid = 1'b0;
		status       = '0;
		shift_in     = '0;
		exp_frame    = '0;
		prev_s_clk   = 1'b1;
		prev_clrn    = 1'b1;
		ready_seen   = 1'b0;
		bit_cnt      = 0;
		clr_count    = 0;
		frames_done  = 0;
		frame_cycles = 0;

		// wait out reset
		waited = 0;
		while (!rst_n) begin
			@(negedge clk200m);
			waited++;
			if (waited > 100) begin
				report_problem("reset never released");
			end
		end

		// levels right after reset
		assert (en === 1'b0) else report_mismatch("en", 64'h0, 64'(en));
		assert (s_clrn === 1'b1) else report_mismatch("s_clrn", 64'h1, 64'(s_clrn));
		assert (s_clk === 1'b1) else report_mismatch("s_clk", 64'h1, 64'(s_clk));
		assert (sout === 1'b0) else report_mismatch("sout", 64'h0, 64'(sout));
		assert (leds === 8'h00) else report_mismatch("leds", 64'h0, 64'(leds));
		assert (status_ready === 1'b0) else begin
			report_mismatch("status_ready", 64'h0, 64'(status_ready));
		end

		// ready comes up within a few cycles
		waited = 0;
		while (!status_ready) begin
			@(negedge clk200m);
			waited++;
			if (waited > 8) begin
				report_problem("status_ready did not rise after reset");
			end
		end

		// directed pass with every nibble value once
		w.inst   = 32'h01234567;
		w.pc_nib = 4'h5;
		w.flush  = 1'b1;
		send_word(w);
		w.inst   = 32'h89abcdef;
		w.pc_nib = 4'ha;
		w.flush  = 1'b0;
		send_word(w);

		// random words mostly offered mid frame
		for (int n = 2; n < NUM_FRAMES; n++) begin
			r = next_random();
			if (r[31:30] == 2'b00) begin
				// long gap lets the link go idle
				gap = 600 + int'(r[3:0]);
			end else begin
				gap = int'(r[17:16]);
			end
			repeat (gap) @(negedge clk200m);
			w.inst   = next_random();
			r        = next_random();
			w.pc_nib = r[27:24];
			w.flush  = r[31];
			send_word(w);
		end

		// drain the last frame
		waited = 0;
		while (frames_done < NUM_FRAMES) begin
			@(negedge clk200m);
			waited++;
			if (waited > FRAME_TIMEOUT) begin
				report_problem("timeout waiting for the last frame");
			end
		end
		waited = 0;
		while (!status_ready) begin
			@(negedge clk200m);
			waited++;
			if (waited > 20) begin
				report_problem("status_ready did not return after the last frame");
			end
		end

		if (frames_done == NUM_FRAMES && q.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			report_problem("frame count does not match the accepted words");
		end
	end

endmodule

`default_nettype wire

/* build.f */
rtl/panel_pkg.sv
rtl/tick_gen.sv
rtl/hex_seg_encoder.sv
rtl/seg_serializer.sv
rtl/panel_ctrl.sv
rtl/panel_top.sv
sim/clk_gen.sv
sim/panel_tb.sv

/* run.sh */
#!/bin/sh
# compile and run the panel testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
	-f build.f --top-module panel_tb -o panel_sim

# the simulator exit code is ignored, the log decides
./obj_dir/panel_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
